// ==== build.f ====
+incdir+.
rv32m_pkg.sv
mul_shift_add.sv
div_restoring.sv
muldiv_sequencer.sv
rv32m_unit.sv
rv32m_unit_tb.sv

// ==== rv32m_ref_model.svh ====
// Testbench reference model of the eight M-extension operations, included inside the testbench
`ifndef RV32M_REF_MODEL_SVH
`define RV32M_REF_MODEL_SVH

function automatic logic [rv32m_pkg::XLEN-1:0] expected_result(
  input rv32m_pkg::muldiv_op_e       op,
  input logic [rv32m_pkg::XLEN-1:0] a,
  input logic [rv32m_pkg::XLEN-1:0] b
);
  logic [2*rv32m_pkg::XLEN-1:0] prod_ss; // signed x signed
  logic [2*rv32m_pkg::XLEN-1:0] prod_su; // signed x unsigned
  logic [2*rv32m_pkg::XLEN-1:0] prod_uu; // unsigned x unsigned
  logic                         div_zero;
  logic                         ovf;
  prod_ss  = {{32{a[31]}}, a} * {{32{b[31]}}, b}; // Low 64 bits exact
  prod_su  = {{32{a[31]}}, a} * {32'b0, b};
  prod_uu  = {32'b0, a} * {32'b0, b};
  div_zero = (b == '0);
  ovf      = (a == rv32m_pkg::MIN_SIGNED) && (b == '1);
  case (op)
    rv32m_pkg::op_mul:    return prod_uu[31:0];
    rv32m_pkg::op_mulh:   return prod_ss[63:32];
    rv32m_pkg::op_mulhsu: return prod_su[63:32];
    rv32m_pkg::op_mulhu:  return prod_uu[63:32];
    rv32m_pkg::op_div: begin
      if (div_zero) return '1;
      if (ovf) return a;
      return $signed(a) / $signed(b); // Truncates toward zero
    end
    rv32m_pkg::op_divu:   return div_zero ? '1 : a / b;
    rv32m_pkg::op_rem: begin
      if (div_zero) return a;
      if (ovf) return '0;
      return $signed(a) % $signed(b); // Sign of the dividend
    end
    rv32m_pkg::op_remu:   return div_zero ? a : a % b;
    default:              return '0;
  endcase
endfunction

`endif

// ==== rv32m_unit_tb.sv ====
// Self-checking testbench of the RV32M unit, drives LFSR and corner requests checked by assertions
`timescale 1ns/1ps

module rv32m_unit_tb;

  logic                       clk;
  logic                       resetn;
  rv32m_pkg::muldiv_req_t     req;
  logic                       valid;
  logic                       ready;
  logic [rv32m_pkg::XLEN-1:0] result;

  logic [31:0]                lfsr;              // Stimulus LFSR state
  logic [rv32m_pkg::XLEN-1:0] exp_result;        // Expected word of the request in flight
  int                         pending = 0;       // Acceptances minus completions
  logic                       seen_valid = 1'b0; // valid asserted at least once
  string                      test_name = "none";

  logic [31:0] corners [5] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                               32'h8000_0000, 32'h7fff_ffff};

  `include "rv32m_ref_model.svh"

  rv32m_unit dut_i (
    .clk    (clk),
    .resetn (resetn),
    .req    (req),
    .valid  (valid),
    .ready  (ready),
    .result (result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 100 MHz
  end

  // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  // Raise valid, hold it until ready, optionally scrambling req once latched
  task automatic run_request(input string tag, input rv32m_pkg::muldiv_op_e op,
                             input logic [31:0] a, input logic [31:0] b, input bit scramble);
    logic [31:0] junk;
    int          cycles;
    @(negedge clk);
    test_name = $sformatf("%s %s", tag, op.name());
    req.op    = op;
    req.a     = a;
    req.b     = b;
    valid     = 1'b1;
    cycles    = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > 100) report_failure("ready never arrived");
      if (scramble && !ready) begin // Accepted on the previous edge
        take_bits(32, junk);
        req.a = junk;
        take_bits(32, junk);
        req.b = junk;
        take_bits(3, junk);
        req.op = rv32m_pkg::muldiv_op_e'(junk[2:0]);
      end
    end while (!ready);
  endtask

  task automatic idle_cycles(input int n);
    @(negedge clk);
    valid = 1'b0;
    repeat (n - 1) @(negedge clk);
  endtask

  // Handshake tracker, expected word taken from the accepted request
  always @(posedge clk) begin
    if (valid) seen_valid <= 1'b1;
    if (!resetn) begin
      pending <= 0;
    end else if (valid && !ready && pending == 0) begin
      pending    <= pending + 1;
      exp_result <= expected_result(req.op, req.a, req.b);
    end else if (ready) begin
      pending <= pending - 1; // Completion
    end
  end

  a_reset_low: assert property (@(posedge clk) !resetn |=> !ready)
    else report_failure("ready was high during reset");
  a_after_reset: assert property (@(posedge clk) $rose(resetn) |-> !ready ##1 !ready)
    else report_failure("ready was high right after reset release");
  a_no_request: assert property (@(posedge clk) (resetn && !seen_valid) |-> !ready)
    else report_failure("ready was high before any request");
  a_single_pulse: assert property (@(posedge clk) disable iff (!resetn) ready |=> !ready)
    else report_failure("ready stayed high for two cycles");
  a_one_per_req: assert property (@(posedge clk) disable iff (!resetn) ready |-> pending == 1)
    else report_failure("ready pulse without an accepted request");
  a_result: assert property (@(posedge clk) disable iff (!resetn) ready |-> result == exp_result)
    else report_failure($sformatf("[FAIL] %s expected %h actual %h",
                                  test_name, exp_result, $sampled(result)));

  initial begin
    logic [31:0]           a;
    logic [31:0]           b;
    logic [31:0]           bits;
    rv32m_pkg::muldiv_op_e op;
    lfsr   = 32'd24; // Seed
    resetn = 1'b0;
    valid  = 1'b0;
    req    = '0;
    repeat (16) @(negedge clk);
    resetn = 1'b1;
    repeat (4) @(negedge clk); // Quiet unit, valid never raised
    for (int k = 4; k < 8; k++) begin // DIV, DIVU, REM, REMU
      op = rv32m_pkg::muldiv_op_e'(k);
      take_bits(32, a);
      run_request("div_zero", op, a, '0, 1'b0);
      run_request("div_zero", op, 32'h8000_0000, '0, 1'b0);
      run_request("overflow", op, 32'h8000_0000, '1, 1'b0);
      run_request("overflow", op, 32'h8000_0000, 32'h0000_0001, 1'b0);
    end
    idle_cycles(3);
    for (int k = 0; k < 8; k++) begin // Every op over every corner pair
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          run_request("corner", rv32m_pkg::muldiv_op_e'(k), corners[i], corners[j], j[0]);
        end
      end
    end
    idle_cycles(3);
    for (int n = 0; n < 300; n++) begin // Back to back, multiply and divide alternate
      take_bits(2, bits);
      op = rv32m_pkg::muldiv_op_e'({n[0], bits[1:0]});
      take_bits(32, a);
      take_bits(32, b);
      take_bits(5, bits);
      b = b >> bits[4:0]; // Short multipliers, small divisors
      run_request((n % 3 == 0) ? "latch" : "b2b", op, a, b, n % 3 == 0);
      if (n % 50 == 49) idle_cycles(2);
    end
    idle_cycles(2);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== rv32m_unit.sv ====
// Top level of the RV32M multiply/divide unit, sequencer plus both iterative engines
`timescale 1ns/1ps

module rv32m_unit (
  input  logic                       clk,
  input  logic                       resetn,
  input  rv32m_pkg::muldiv_req_t     req,
  input  logic                       valid,
  output logic                       ready,
  output logic [rv32m_pkg::XLEN-1:0] result
);

  rv32m_pkg::engine_cmd_t     cmd;        // Shared by both engines
  logic                       mul_start;
  logic                       div_start;
  logic                       mul_done;
  logic                       div_done;
  logic [rv32m_pkg::XLEN-1:0] mul_result;
  logic [rv32m_pkg::XLEN-1:0] div_result;

  muldiv_sequencer seq_i (
    .clk        (clk),
    .resetn     (resetn),
    .req        (req),
    .valid      (valid),
    .mul_done   (mul_done),
    .div_done   (div_done),
    .mul_result (mul_result),
    .div_result (div_result),
    .ready      (ready),
    .result     (result),
    .cmd        (cmd),
    .mul_start  (mul_start),
    .div_start  (div_start)
  );

  mul_shift_add mul_i (
    .clk    (clk),
    .resetn (resetn),
    .cmd    (cmd),
    .start  (mul_start),
    .done   (mul_done),
    .result (mul_result)
  );

  div_restoring div_i (
    .clk    (clk),
    .resetn (resetn),
    .cmd    (cmd),
    .start  (div_start),
    .done   (div_done),
    .result (div_result)
  );

endmodule

// ==== muldiv_sequencer.sv ====
// Request sequencer of the RV32M unit, latches a request, starts one engine and returns its result
`timescale 1ns/1ps

module muldiv_sequencer (
  input  logic                       clk,
  input  logic                       resetn,
  input  rv32m_pkg::muldiv_req_t     req,
  input  logic                       valid,
  input  logic                       mul_done,
  input  logic                       div_done,
  input  logic [rv32m_pkg::XLEN-1:0] mul_result,
  input  logic [rv32m_pkg::XLEN-1:0] div_result,
  output logic                       ready,
  output logic [rv32m_pkg::XLEN-1:0] result,
  output rv32m_pkg::engine_cmd_t     cmd,
  output logic                       mul_start,
  output logic                       div_start
);

  typedef enum logic [1:0] {
    st_idle, // Accepting
    st_busy, // Engine running
    st_resp  // ready pulse
  } seq_state_e;

  seq_state_e state;

  logic use_div;  // Engine started for the current request
  logic accept;
  logic is_div;
  logic eng_done; // Done of the started engine only
  logic dec_a_signed;
  logic dec_b_signed;
  logic dec_sel_alt;

  assign accept = (state == st_idle) && valid && !ready;

  // funct3 decode
  assign is_div       = req.op[2]; // Upper half of the encoding is divide
  assign dec_a_signed = (req.op == rv32m_pkg::op_mulh)   || (req.op == rv32m_pkg::op_mulhsu) ||
                        (req.op == rv32m_pkg::op_div)    || (req.op == rv32m_pkg::op_rem);
  assign dec_b_signed = (req.op == rv32m_pkg::op_mulh)   || (req.op == rv32m_pkg::op_div) ||
                        (req.op == rv32m_pkg::op_rem);
  assign dec_sel_alt  = (req.op == rv32m_pkg::op_mulh)   || (req.op == rv32m_pkg::op_mulhsu) ||
                        (req.op == rv32m_pkg::op_mulhu)  || (req.op == rv32m_pkg::op_rem) ||
                        (req.op == rv32m_pkg::op_remu);

  assign eng_done = use_div ? div_done : mul_done;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= st_idle;
      use_div   <= 1'b0;
      ready     <= 1'b0;
      mul_start <= 1'b0;
      div_start <= 1'b0;
    end else begin
      mul_start <= 1'b0; // Strobes last one cycle
      div_start <= 1'b0;
      ready     <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            use_div   <= is_div;
            mul_start <= !is_div;
            div_start <= is_div;
            state     <= st_busy;
          end
        end
        st_busy: begin
          if (eng_done) begin
            ready <= 1'b1;
            state <= st_resp;
          end
        end
        st_resp: state <= st_idle; // ready high here
        default: state <= st_idle;
      endcase
    end
  end

  // Operands latched on acceptance, result on engine done
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd.a        <= req.a;
      cmd.b        <= req.b;
      cmd.a_signed <= dec_a_signed;
      cmd.b_signed <= dec_b_signed;
      cmd.sel_alt  <= dec_sel_alt;
    end
    if (state == st_busy && eng_done) begin
      result <= use_div ? div_result : mul_result;
    end
  end

endmodule

// ==== div_restoring.sv ====
// Iterative restoring divider engine, started by the sequencer, returns quotient or remainder
`timescale 1ns/1ps

module div_restoring (
  input  logic                       clk,
  input  logic                       resetn,
  input  rv32m_pkg::engine_cmd_t     cmd,
  input  logic                       start,
  output logic                       done,
  output logic [rv32m_pkg::XLEN-1:0] result
);

  localparam int CNT_W = $clog2(rv32m_pkg::XLEN);

  typedef enum logic [1:0] {
    st_idle, // Waiting for start
    st_calc, // One quotient bit per cycle
    st_fix   // Sign fix, done high
  } div_state_e;

  div_state_e state;

  logic [CNT_W-1:0]           cnt;     // Steps left minus one
  logic [rv32m_pkg::XLEN-1:0] quo;     // Dividend shifting out, quotient shifting in
  logic [rv32m_pkg::XLEN-1:0] rem;     // Partial remainder
  logic [rv32m_pkg::XLEN-1:0] divisor; // Divisor magnitude
  logic [rv32m_pkg::XLEN-1:0] a_mag;
  logic [rv32m_pkg::XLEN-1:0] b_mag;
  logic [rv32m_pkg::XLEN-1:0] word;
  logic [rv32m_pkg::XLEN:0]   shifted; // Remainder with next dividend bit
  logic [rv32m_pkg::XLEN:0]   diff;
  logic                       fits;    // Divisor fits, quotient bit is one
  logic                       a_neg;
  logic                       b_neg;
  logic                       neg;     // Sign of the selected word
  logic                       div_zero;
  logic                       ovf;
  logic                       special;

  assign a_neg = cmd.a_signed & cmd.a[rv32m_pkg::XLEN-1];
  assign b_neg = cmd.b_signed & cmd.b[rv32m_pkg::XLEN-1];
  assign a_mag = a_neg ? -cmd.a : cmd.a;
  assign b_mag = b_neg ? -cmd.b : cmd.b;

  // ISA special cases, both resolved at load
  assign div_zero = (cmd.b == '0);
  assign ovf      = cmd.a_signed & cmd.b_signed & (cmd.a == rv32m_pkg::MIN_SIGNED) &
                    (cmd.b == '1);
  assign special  = div_zero | ovf;

  // Restoring step, top bit of diff is the borrow
  assign shifted = {rem, quo[rv32m_pkg::XLEN-1]};
  assign diff    = shifted - {1'b0, divisor};
  assign fits    = ~diff[rv32m_pkg::XLEN];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= special ? st_fix : st_calc; // Specials skip the loop
            cnt   <= CNT_W'(rv32m_pkg::XLEN - 1);
          end
        end
        st_calc: begin
          cnt <= cnt - 1'b1;
          if (cnt == '0) state <= st_fix; // Always 32 steps
        end
        st_fix:  state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (state == st_idle && start) begin
      divisor <= b_mag;
      if (div_zero) begin
        quo <= '1;    // Quotient all ones
        rem <= cmd.a; // Remainder is the dividend
        neg <= 1'b0;
      end else if (ovf) begin
        quo <= cmd.a; // Quotient is the dividend
        rem <= '0;
        neg <= 1'b0;
      end else begin
        quo <= a_mag;
        rem <= '0;
        neg <= cmd.sel_alt ? a_neg : (a_neg ^ b_neg); // Remainder follows dividend
      end
    end else if (state == st_calc) begin
      rem <= fits ? diff[rv32m_pkg::XLEN-1:0] : shifted[rv32m_pkg::XLEN-1:0];
      quo <= {quo[rv32m_pkg::XLEN-2:0], fits};
    end
  end

  assign done = (state == st_fix);

  assign word   = cmd.sel_alt ? rem : quo;
  assign result = neg ? -word : word; // Sign fix

endmodule

// ==== mul_shift_add.sv ====
// Iterative shift-and-add multiplier engine, started by the sequencer, returns low or high word
`timescale 1ns/1ps

module mul_shift_add (
  input  logic                      clk,
  input  logic                      resetn,
  input  rv32m_pkg::engine_cmd_t    cmd,
  input  logic                      start,
  output logic                      done,
  output logic [rv32m_pkg::XLEN-1:0] result
);

  typedef enum logic [1:0] {
    st_idle, // Waiting for start
    st_calc, // One multiplier bit per cycle
    st_fix   // Sign fix, done high
  } mul_state_e;

  mul_state_e state;

  logic [2*rv32m_pkg::XLEN-1:0] mcand;      // Shifting multiplicand
  logic [2*rv32m_pkg::XLEN-1:0] prod;       // Running magnitude product
  logic [2*rv32m_pkg::XLEN-1:0] prod_fixed; // Signed product
  logic [rv32m_pkg::XLEN-1:0]   mplier;     // Remaining multiplier bits
  logic [rv32m_pkg::XLEN-1:0]   a_mag;
  logic [rv32m_pkg::XLEN-1:0]   b_mag;
  logic                         a_neg;
  logic                         b_neg;
  logic                         neg;        // Product sign noted at load
  logic                         last_step;

  // Operand magnitudes, min signed maps onto itself as unsigned 2^31
  assign a_neg = cmd.a_signed & cmd.a[rv32m_pkg::XLEN-1];
  assign b_neg = cmd.b_signed & cmd.b[rv32m_pkg::XLEN-1];
  assign a_mag = a_neg ? -cmd.a : cmd.a;
  assign b_mag = b_neg ? -cmd.b : cmd.b;

  // Stop once nothing is left above the current bit
  assign last_step = (mplier[rv32m_pkg::XLEN-1:1] == '0);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (start) state <= st_calc; // Load cycle
        st_calc: if (last_step) state <= st_fix; // At least one step
        st_fix:  state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (state == st_idle && start) begin
      mcand  <= {{rv32m_pkg::XLEN{1'b0}}, a_mag}; // Zero extend to 64 bits
      mplier <= b_mag;
      prod   <= '0;
      neg    <= a_neg ^ b_neg;
    end else if (state == st_calc) begin
      if (mplier[0]) begin
        prod <= prod + mcand; // Add on set bit
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign done = (state == st_fix);

  // Sign fix on the full 64 bits, then word select
  assign prod_fixed = neg ? -prod : prod;
  assign result     = cmd.sel_alt ? prod_fixed[2*rv32m_pkg::XLEN-1:rv32m_pkg::XLEN]
                                  : prod_fixed[rv32m_pkg::XLEN-1:0];

endmodule

// ==== rv32m_pkg.sv ====
// Shared width, funct3 encoding and request/engine structs of the RV32M multiply/divide unit
package rv32m_pkg;

  // Data width fixed by the ISA
  localparam int XLEN = 32;

  // Most negative two's complement word
  localparam logic [XLEN-1:0] MIN_SIGNED = {1'b1, {(XLEN-1){1'b0}}};

  // funct3 codes of the M extension
  typedef enum logic [2:0] {
    op_mul    = 3'b000, // Low word, sign agnostic
    op_mulh   = 3'b001, // High word, signed x signed
    op_mulhsu = 3'b010, // High word, signed x unsigned
    op_mulhu  = 3'b011, // High word, unsigned x unsigned
    op_div    = 3'b100, // Signed quotient
    op_divu   = 3'b101, // Unsigned quotient
    op_rem    = 3'b110, // Signed remainder
    op_remu   = 3'b111  // Unsigned remainder
  } muldiv_op_e;

  // Request as seen at the unit boundary
  typedef struct packed {
    muldiv_op_e      op; // funct3
    logic [XLEN-1:0] a;  // rs1
    logic [XLEN-1:0] b;  // rs2
  } muldiv_req_t;

  // Decoded command shared by both engines
  // Held stable by the sequencer from start to done
  typedef struct packed {
    logic [XLEN-1:0] a;        // Multiplicand or dividend
    logic [XLEN-1:0] b;        // Multiplier or divisor
    logic            a_signed; // a is two's complement
    logic            b_signed; // b is two's complement
    logic            sel_alt;  // High word or remainder
  } engine_cmd_t;

endpackage
